/* design/spi_osd_params.svh */
`ifndef SPI_OSD_PARAMS_SVH
`define SPI_OSD_PARAMS_SVH

// horizontal timing in pixels, 80 per line
`define H_ACTIVE 64
`define H_FRONT 4
`define H_SYNC 8
`define H_BACK 4
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)
`define X_BITS 7

// vertical timing in lines, 20 per frame
`define V_ACTIVE 16
`define V_FRONT 1
`define V_SYNC 2
`define V_BACK 1
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)
`define Y_BITS 5

// 128 bytes of bitmap, 8 bytes per line
`define OSD_RAM_BITS 7

`define OSD_FG_R 8'hff
`define OSD_FG_G 8'hc0
`define OSD_FG_B 8'h20
`define OSD_DELAY 8

`endif

/* design/spi_osd_pkg.sv */
`include "spi_osd_params.svh"

package spi_osd_pkg;

  typedef logic [7:0] osd_byte_t;

  typedef logic [`OSD_RAM_BITS-1:0] osd_addr_t;

  // region 0x00 is the bitmap, region 0x01 the control register
  typedef struct packed {
    logic [7:0]  region;
    logic [23:0] offset;
  } spi_addr_fields_t;

  // same 32 bits, seen as shifted in or as region plus offset
  typedef union packed {
    logic [31:0]      raw;
    spi_addr_fields_t field;
  } spi_addr_u;

endpackage

/* design/spi_ram_slave.sv */
`timescale 1ns/1ns

module spi_ram_slave (
  input  logic                   clk_cpu,
  input  logic                   i_rst_n,
  input  logic                   i_csn,
  input  logic                   i_sclk,
  input  logic                   i_mosi,
  output logic                   o_miso,
  output logic                   o_osd_en,
  output logic                   o_mem_req,
  output logic                   o_mem_we,
  output spi_osd_pkg::osd_addr_t o_mem_addr,
  output spi_osd_pkg::osd_byte_t o_mem_wdata,
  input  logic                   i_mem_ack,
  input  spi_osd_pkg::osd_byte_t i_mem_rdata
);

  logic [1:0] csn_sync;
  logic [2:0] sclk_sync;
  logic [1:0] mosi_sync;
  logic       sclk_rise;
  logic       sclk_fall;
  logic       csn_act;
  logic       byte_done;
  logic [2:0] bit_cnt;
  // 0 command, 1 to 4 address, 5 data
  logic [2:0] byte_cnt;
  logic [6:0] shift_in;
  logic       rd_cmd;
  logic       issue;
  spi_osd_pkg::spi_addr_u addr;
  spi_osd_pkg::osd_byte_t rx_byte;
  spi_osd_pkg::osd_byte_t wr_byte;
  spi_osd_pkg::osd_byte_t tx_buf;
  spi_osd_pkg::osd_byte_t tx_sr;

  // sclk is not clock capable, so everything is oversampled
  always_ff @(posedge clk_cpu)
  begin
    if (!i_rst_n)
    begin
      csn_sync  <= 2'b11;
      sclk_sync <= '0;
      mosi_sync <= '0;
    end
    else
    begin
      csn_sync  <= {csn_sync[0], i_csn};
      sclk_sync <= {sclk_sync[1:0], i_sclk};
      mosi_sync <= {mosi_sync[0], i_mosi};
    end
  end

  assign csn_act   = ~csn_sync[1];
  assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
  assign rx_byte   = {shift_in, mosi_sync[1]};
  assign byte_done = csn_act && sclk_rise && (bit_cnt == 3'd7);

  always_ff @(posedge clk_cpu)
  begin
    if (!i_rst_n)
    begin
      bit_cnt   <= '0;
      byte_cnt  <= '0;
      rd_cmd    <= 1'b0;
      issue     <= 1'b0;
      o_miso    <= 1'b0;
      o_osd_en  <= 1'b0;
      o_mem_req <= 1'b0;
      o_mem_we  <= 1'b0;
      tx_buf    <= '0;
      tx_sr     <= '0;
    end
    else
    begin
      issue <= 1'b0;
      if (!csn_act)
      begin
        // a started memory access still runs to its ack
        bit_cnt  <= '0;
        byte_cnt <= '0;
        rd_cmd   <= 1'b0;
        o_miso   <= 1'b0;
        tx_buf   <= '0;
        tx_sr    <= '0;
      end
      else
      begin
        if (sclk_rise)
        begin
          bit_cnt <= bit_cnt + 3'd1;
        end
        if (byte_done)
        begin
          if (byte_cnt == 3'd0)
          begin
            rd_cmd <= rx_byte[0];
          end
          if (byte_cnt != 3'd5)
          begin
            byte_cnt <= byte_cnt + 3'd1;
          end
          // reads prefetch right after the address, then after every byte
          issue <= (byte_cnt == 3'd4 && rd_cmd) || (byte_cnt == 3'd5);
        end
        if (sclk_fall)
        begin
          if (bit_cnt == 3'd0)
          begin
            o_miso <= tx_buf[7];
            tx_sr  <= {tx_buf[6:0], 1'b0};
          end
          else
          begin
            o_miso <= tx_sr[7];
            tx_sr  <= {tx_sr[6:0], 1'b0};
          end
        end
      end
      if (issue && addr.field.region == 8'h00)
      begin
        o_mem_req <= 1'b1;
        o_mem_we  <= ~rd_cmd;
      end
      else if (issue && addr.field.region == 8'h01)
      begin
        if (rd_cmd)
          tx_buf <= {7'd0, o_osd_en};
        else
          o_osd_en <= wr_byte[0];
      end
      if (i_mem_ack)
      begin
        o_mem_req <= 1'b0;
        if (rd_cmd)
          tx_buf <= i_mem_rdata;
      end
    end
  end

  always_ff @(posedge clk_cpu)
  begin
    if (sclk_rise)
      shift_in <= rx_byte[6:0];
    if (byte_done && byte_cnt >= 3'd1 && byte_cnt <= 3'd4)
      addr.raw <= {addr.raw[23:0], rx_byte};
    if (byte_done && byte_cnt == 3'd5)
      wr_byte <= rx_byte;
    if (issue)
      o_mem_addr <= spi_osd_pkg::osd_addr_t'(addr.field.offset);
    if (i_mem_ack)
      addr.field.offset <= addr.field.offset + 24'd1;
  end

  assign o_mem_wdata = wr_byte;

endmodule

/* design/mem_arbiter.sv */
`timescale 1ns/1ns

module mem_arbiter (
  input  logic                   clk_cpu,
  input  logic                   i_rst_n,
  input  logic                   i_spi_req,
  input  logic                   i_spi_we,
  input  spi_osd_pkg::osd_addr_t i_spi_addr,
  input  spi_osd_pkg::osd_byte_t i_spi_wdata,
  output logic                   o_spi_ack,
  output spi_osd_pkg::osd_byte_t o_spi_rdata,
  input  logic                   i_osd_fetch,
  input  spi_osd_pkg::osd_addr_t i_osd_addr,
  output logic                   o_osd_valid,
  output spi_osd_pkg::osd_byte_t o_osd_rdata,
  output logic                   o_ram_we,
  output spi_osd_pkg::osd_addr_t o_ram_addr,
  output spi_osd_pkg::osd_byte_t o_ram_wdata,
  input  spi_osd_pkg::osd_byte_t i_ram_rdata
);

  logic spi_grant;
  logic spi_owner;
  logic osd_owner;

  // overlay first; no second spi grant while its ack is due
  assign spi_grant = i_spi_req && !i_osd_fetch && !spi_owner;

  assign o_ram_we    = spi_grant & i_spi_we;
  assign o_ram_addr  = i_osd_fetch ? i_osd_addr : i_spi_addr;
  assign o_ram_wdata = i_spi_wdata;

  // ram read data shows up one cycle after the grant
  always_ff @(posedge clk_cpu)
  begin
    if (!i_rst_n)
    begin
      spi_owner <= 1'b0;
      osd_owner <= 1'b0;
    end
    else
    begin
      spi_owner <= spi_grant;
      osd_owner <= i_osd_fetch;
    end
  end

  assign o_spi_ack   = spi_owner;
  assign o_osd_valid = osd_owner;
  assign o_spi_rdata = spi_owner ? i_ram_rdata : '0;
  assign o_osd_rdata = osd_owner ? i_ram_rdata : '0;

endmodule

/* design/osd_ram.sv */
`timescale 1ns/1ns
`include "spi_osd_params.svh"

module osd_ram (
  input  logic                   clk_cpu,
  input  logic                   i_we,
  input  spi_osd_pkg::osd_addr_t i_addr,
  input  spi_osd_pkg::osd_byte_t i_wdata,
  output spi_osd_pkg::osd_byte_t o_rdata
);

  spi_osd_pkg::osd_byte_t mem [0:(1 << `OSD_RAM_BITS)-1];

  // read first so a write shows up on the next access
  always_ff @(posedge clk_cpu)
  begin
    if (i_we)
      mem[i_addr] <= i_wdata;
    o_rdata <= mem[i_addr];
  end

endmodule

/* design/video_timing.sv */
`timescale 1ns/1ns
`include "spi_osd_params.svh"

module video_timing (
  input  logic              clk_cpu,
  input  logic              i_rst_n,
  output logic [`X_BITS-1:0] o_x,
  output logic [`Y_BITS-1:0] o_y,
  output logic              o_hsync,
  output logic              o_vsync,
  output logic              o_blank,
  output logic [7:0]        o_r,
  output logic [7:0]        o_g,
  output logic [7:0]        o_b
);

  localparam int HS_START = `H_ACTIVE + `H_FRONT;
  localparam int HS_END   = HS_START + `H_SYNC;
  localparam int VS_START = `V_ACTIVE + `V_FRONT;
  localparam int VS_END   = VS_START + `V_SYNC;

  logic [7:0] pic_r;
  logic [7:0] pic_g;
  logic [7:0] pic_b;

  always_ff @(posedge clk_cpu)
  begin
    if (!i_rst_n)
    begin
      o_x <= '0;
      o_y <= '0;
    end
    else if (o_x == `H_TOTAL - 1)
    begin
      o_x <= '0;
      if (o_y == `V_TOTAL - 1)
        o_y <= '0;
      else
        o_y <= o_y + 1'b1;
    end
    else
    begin
      o_x <= o_x + 1'b1;
    end
  end

  assign o_hsync = (o_x >= HS_START) && (o_x < HS_END);
  assign o_vsync = (o_y >= VS_START) && (o_y < VS_END);
  assign o_blank = (o_x >= `H_ACTIVE) || (o_y >= `V_ACTIVE);

  // horizontal red ramp and vertical green bands
  assign pic_r = 8'(o_x) << 2;
  assign pic_g = 8'(o_y) << 4;
  assign pic_b = 8'(o_x) + 8'(o_y);

  assign o_r = o_blank ? 8'd0 : pic_r;
  assign o_g = o_blank ? 8'd0 : pic_g;
  assign o_b = o_blank ? 8'd0 : pic_b;

endmodule

/* design/osd_overlay.sv */
`timescale 1ns/1ns
`include "spi_osd_params.svh"

module osd_overlay (
  input  logic                   clk_cpu,
  input  logic                   i_rst_n,
  input  logic                   i_osd_en,
  input  logic [`X_BITS-1:0]     i_x,
  input  logic [`Y_BITS-1:0]     i_y,
  input  logic [7:0]             i_r,
  input  logic [7:0]             i_g,
  input  logic [7:0]             i_b,
  input  logic                   i_hsync,
  input  logic                   i_vsync,
  input  logic                   i_blank,
  output logic                   o_fetch,
  output spi_osd_pkg::osd_addr_t o_fetch_addr,
  input  logic                   i_fetch_valid,
  input  spi_osd_pkg::osd_byte_t i_fetch_data,
  output logic [7:0]             o_r,
  output logic [7:0]             o_g,
  output logic [7:0]             o_b,
  output logic                   o_hsync,
  output logic                   o_vsync,
  output logic                   o_blank
);

  localparam int D = `OSD_DELAY;

  logic [7:0]   dl_r [D];
  logic [7:0]   dl_g [D];
  logic [7:0]   dl_b [D];
  logic [2:0]   dl_x [D];
  logic [D-1:0] dl_hs;
  logic [D-1:0] dl_vs;
  logic [D-1:0] dl_bl;
  logic [2:0]   out_x;
  logic         pix_on;
  spi_osd_pkg::osd_byte_t fetch_byte;
  spi_osd_pkg::osd_byte_t hold_byte;
  spi_osd_pkg::osd_byte_t cur_byte;

  // one fetch per 8 active pixels, at y*8 + x/8
  assign o_fetch      = !i_blank && (i_x[2:0] == 3'd0);
  assign o_fetch_addr = spi_osd_pkg::osd_addr_t'({i_y, 3'b000} + (i_x >> 3));

  always_ff @(posedge clk_cpu)
  begin
    if (!i_rst_n)
    begin
      dl_hs <= '0;
      dl_vs <= '0;
      dl_bl <= '1;
    end
    else
    begin
      dl_hs <= {dl_hs[D-2:0], i_hsync};
      dl_vs <= {dl_vs[D-2:0], i_vsync};
      dl_bl <= {dl_bl[D-2:0], i_blank};
    end
  end

  always_ff @(posedge clk_cpu)
  begin
    dl_r[0] <= i_r;
    dl_g[0] <= i_g;
    dl_b[0] <= i_b;
    dl_x[0] <= i_x[2:0];
    for (int i = 1; i < D; i++)
    begin
      dl_r[i] <= dl_r[i-1];
      dl_g[i] <= dl_g[i-1];
      dl_b[i] <= dl_b[i-1];
      dl_x[i] <= dl_x[i-1];
    end
    if (i_fetch_valid)
      fetch_byte <= i_fetch_data;
    // next fetch lands mid group, so keep the byte for its last 7 pixels
    if (out_x == 3'd0)
      hold_byte <= fetch_byte;
  end

  assign out_x    = dl_x[D-1];
  assign cur_byte = (out_x == 3'd0) ? fetch_byte : hold_byte;
  // msb is the leftmost pixel
  assign pix_on   = cur_byte[~out_x];

  assign o_hsync = dl_hs[D-1];
  assign o_vsync = dl_vs[D-1];
  assign o_blank = dl_bl[D-1];

  always_comb
  begin
    o_r = dl_r[D-1];
    o_g = dl_g[D-1];
    o_b = dl_b[D-1];
    if (i_osd_en && !o_blank)
    begin
      if (pix_on)
      begin
        o_r = `OSD_FG_R;
        o_g = `OSD_FG_G;
        o_b = `OSD_FG_B;
      end
      else
      begin
        // dim the picture behind clear pixels
        o_r = {1'b0, dl_r[D-1][7:1]};
        o_g = {1'b0, dl_g[D-1][7:1]};
        o_b = {1'b0, dl_b[D-1][7:1]};
      end
    end
  end

endmodule

/* design/osd_char_top.sv */
`timescale 1ns/1ns
`include "spi_osd_params.svh"

module osd_char_top (
  input  logic       clk_cpu,
  input  logic       i_rst_n,
  input  logic       i_spi_csn,
  input  logic       i_spi_sclk,
  input  logic       i_spi_mosi,
  output logic       o_spi_miso,
  output logic [7:0] o_r,
  output logic [7:0] o_g,
  output logic [7:0] o_b,
  output logic       o_hsync,
  output logic       o_vsync,
  output logic       o_blank
);

  logic                   osd_en;
  logic                   spi_req;
  logic                   spi_we;
  logic                   spi_ack;
  spi_osd_pkg::osd_addr_t spi_addr;
  spi_osd_pkg::osd_byte_t spi_wdata;
  spi_osd_pkg::osd_byte_t spi_rdata;
  logic                   fetch;
  logic                   fetch_valid;
  spi_osd_pkg::osd_addr_t fetch_addr;
  spi_osd_pkg::osd_byte_t fetch_data;
  logic                   ram_we;
  spi_osd_pkg::osd_addr_t ram_addr;
  spi_osd_pkg::osd_byte_t ram_wdata;
  spi_osd_pkg::osd_byte_t ram_rdata;
  logic [`X_BITS-1:0]     vid_x;
  logic [`Y_BITS-1:0]     vid_y;
  logic                   vid_hsync;
  logic                   vid_vsync;
  logic                   vid_blank;
  logic [7:0]             vid_r;
  logic [7:0]             vid_g;
  logic [7:0]             vid_b;

  spi_ram_slave u_spi (
    .clk_cpu(clk_cpu), .i_rst_n(i_rst_n),
    .i_csn(i_spi_csn), .i_sclk(i_spi_sclk), .i_mosi(i_spi_mosi),
    .o_miso(o_spi_miso), .o_osd_en(osd_en),
    .o_mem_req(spi_req), .o_mem_we(spi_we), .o_mem_addr(spi_addr),
    .o_mem_wdata(spi_wdata), .i_mem_ack(spi_ack), .i_mem_rdata(spi_rdata)
  );

  mem_arbiter u_arb (
    .clk_cpu(clk_cpu), .i_rst_n(i_rst_n),
    .i_spi_req(spi_req), .i_spi_we(spi_we), .i_spi_addr(spi_addr),
    .i_spi_wdata(spi_wdata), .o_spi_ack(spi_ack), .o_spi_rdata(spi_rdata),
    .i_osd_fetch(fetch), .i_osd_addr(fetch_addr),
    .o_osd_valid(fetch_valid), .o_osd_rdata(fetch_data),
    .o_ram_we(ram_we), .o_ram_addr(ram_addr), .o_ram_wdata(ram_wdata),
    .i_ram_rdata(ram_rdata)
  );

  osd_ram u_ram (
    .clk_cpu(clk_cpu), .i_we(ram_we), .i_addr(ram_addr),
    .i_wdata(ram_wdata), .o_rdata(ram_rdata)
  );

  video_timing u_vid (
    .clk_cpu(clk_cpu), .i_rst_n(i_rst_n), .o_x(vid_x), .o_y(vid_y),
    .o_hsync(vid_hsync), .o_vsync(vid_vsync), .o_blank(vid_blank),
    .o_r(vid_r), .o_g(vid_g), .o_b(vid_b)
  );

  osd_overlay u_osd (
    .clk_cpu(clk_cpu), .i_rst_n(i_rst_n), .i_osd_en(osd_en),
    .i_x(vid_x), .i_y(vid_y), .i_r(vid_r), .i_g(vid_g), .i_b(vid_b),
    .i_hsync(vid_hsync), .i_vsync(vid_vsync), .i_blank(vid_blank),
    .o_fetch(fetch), .o_fetch_addr(fetch_addr),
    .i_fetch_valid(fetch_valid), .i_fetch_data(fetch_data),
    .o_r(o_r), .o_g(o_g), .o_b(o_b),
    .o_hsync(o_hsync), .o_vsync(o_vsync), .o_blank(o_blank)
  );

endmodule

/* test/spi_osd_tb.sv */
`timescale 1ns/1ns
`include "spi_osd_params.svh"

module spi_osd_tb;

  localparam int HALF         = 10;
  localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
  localparam int BYTE_CYCLES  = 16 * HALF;
  // two 133 byte blocks plus four 6 byte control transfers, in six transactions
  localparam int SPI_CYCLES   = 290 * BYTE_CYCLES + 6 * 4 * HALF;
  // lock plus four frame checks, each up to two frames
  localparam int LIMIT        = 10 * FRAME_CYCLES + SPI_CYCLES + 2000;

  logic       clk_cpu;
  logic       rst_n;
  logic       spi_csn;
  logic       spi_sclk;
  logic       spi_mosi;
  logic       spi_miso;
  logic [7:0] vid_r;
  logic [7:0] vid_g;
  logic [7:0] vid_b;
  logic       vid_hsync;
  logic       vid_vsync;
  logic       vid_blank;

  spi_osd_pkg::osd_byte_t tx_data [128];
  spi_osd_pkg::osd_byte_t rx_data [128];
  spi_osd_pkg::osd_byte_t bitmap [128];
  spi_osd_pkg::osd_byte_t exp_r;
  spi_osd_pkg::osd_byte_t exp_g;
  spi_osd_pkg::osd_byte_t exp_b;

  integer seed;
  int     cycles;
  int     errors;
  int     start_errors;
  int     tests_run;
  int     tests_failed;

  // video monitor state
  logic locked;
  logic prev_hs;
  logic prev_vs;
  logic prev_bl;
  logic frame_req;
  logic frame_on;
  logic frame_done;
  logic frame_cmp;
  logic frame_en;
  logic exp_active;
  int   mx;
  int   my;
  int   pix_count;
  int   hs_count;
  int   vs_count;
  int   line_count;

  osd_char_top dut (
    .clk_cpu(clk_cpu), .i_rst_n(rst_n),
    .i_spi_csn(spi_csn), .i_spi_sclk(spi_sclk), .i_spi_mosi(spi_mosi),
    .o_spi_miso(spi_miso), .o_r(vid_r), .o_g(vid_g), .o_b(vid_b),
    .o_hsync(vid_hsync), .o_vsync(vid_vsync), .o_blank(vid_blank)
  );

  initial
  begin
    clk_cpu = 1'b0;
    forever #50 clk_cpu = ~clk_cpu;
  end

  always @(posedge clk_cpu)
  begin
    cycles++;
    if (cycles > LIMIT)
    begin
      $display("timeout: the run went past %0d cycles without finishing", LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  task automatic compare_byte(input spi_osd_pkg::osd_byte_t got,
                              input spi_osd_pkg::osd_byte_t exp,
                              input string what, input int index);
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t: %s %0d is %h, expected %h", $time, what, index, got, exp);
    end
  endtask

  task automatic compare_pixel(input spi_osd_pkg::osd_byte_t r,
                               input spi_osd_pkg::osd_byte_t g,
                               input spi_osd_pkg::osd_byte_t b,
                               input spi_osd_pkg::osd_byte_t er,
                               input spi_osd_pkg::osd_byte_t eg,
                               input spi_osd_pkg::osd_byte_t eb,
                               input int x, input int y);
    if (r !== er || g !== eg || b !== eb)
    begin
      errors++;
      $display("error at %0t: pixel x %0d y %0d is %h %h %h, expected %h %h %h",
               $time, x, y, r, g, b, er, eg, eb);
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string what,
                             input int x, input int y);
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t: %s at x %0d y %0d is %b, expected %b",
               $time, what, x, y, got, exp);
    end
  endtask

  task automatic compare_count(input int got, input int exp, input string what);
    if (got != exp)
    begin
      errors++;
      $display("error at %0t: %s counted %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // test picture, dimmed or covered by the bitmap when the overlay is on
  task automatic expected_pixel(input int x, input int y, input logic en);
    spi_osd_pkg::osd_byte_t bits;
    exp_r = spi_osd_pkg::osd_byte_t'(x * 4);
    exp_g = spi_osd_pkg::osd_byte_t'(y * 16);
    exp_b = spi_osd_pkg::osd_byte_t'(x + y);
    bits  = bitmap[y * 8 + x / 8];
    if (en && bits[7 - (x % 8)])
    begin
      exp_r = `OSD_FG_R;
      exp_g = `OSD_FG_G;
      exp_b = `OSD_FG_B;
    end
    else if (en)
    begin
      exp_r = exp_r >> 1;
      exp_g = exp_g >> 1;
      exp_b = exp_b >> 1;
    end
  endtask

  // position comes from the first active pixel, then runs on the macro totals
  always @(negedge clk_cpu)
  begin
    if (!locked && rst_n && vid_blank === 1'b0)
    begin
      locked = 1'b1;
      mx = 0;
      my = 0;
    end
    if (!locked)
    begin
      compare_bit(vid_hsync, 1'b0, "hsync before first line", -1, -1);
      compare_bit(vid_vsync, 1'b0, "vsync before first line", -1, -1);
    end
    else
    begin
      if (mx == 0 && my == 0)
      begin
        if (frame_on)
        begin
          frame_on   = 1'b0;
          frame_done = 1'b1;
        end
        if (frame_req)
        begin
          frame_req  = 1'b0;
          frame_on   = 1'b1;
          pix_count  = 0;
          hs_count   = 0;
          vs_count   = 0;
          line_count = 0;
        end
      end
      exp_active = (mx < `H_ACTIVE) && (my < `V_ACTIVE);
      compare_bit(vid_blank, !exp_active, "blank", mx, my);
      compare_bit(vid_hsync, (mx >= `H_ACTIVE + `H_FRONT) &&
                  (mx < `H_ACTIVE + `H_FRONT + `H_SYNC), "hsync", mx, my);
      compare_bit(vid_vsync, (my >= `V_ACTIVE + `V_FRONT) &&
                  (my < `V_ACTIVE + `V_FRONT + `V_SYNC), "vsync", mx, my);
      if (frame_on)
      begin
        if (vid_hsync && !prev_hs)
          hs_count++;
        if (vid_vsync && !prev_vs)
          vs_count++;
        if (!vid_blank && prev_bl)
          line_count++;
        if (!vid_blank)
          pix_count++;
        if (frame_cmp && exp_active)
        begin
          expected_pixel(mx, my, frame_en);
          compare_pixel(vid_r, vid_g, vid_b, exp_r, exp_g, exp_b, mx, my);
        end
        else if (frame_cmp)
        begin
          // picture is black outside the active area
          compare_pixel(vid_r, vid_g, vid_b, 8'h00, 8'h00, 8'h00, mx, my);
        end
      end
      mx++;
      if (mx == `H_TOTAL)
      begin
        mx = 0;
        my = (my == `V_TOTAL - 1) ? 0 : my + 1;
      end
    end
    prev_hs = vid_hsync;
    prev_vs = vid_vsync;
    prev_bl = vid_blank;
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_cpu);
  endtask

  // one whole frame from pixel 0 of line 0 to the next frame start
  task automatic run_frame(input logic cmp, input logic en);
    @(posedge clk_cpu);
    frame_cmp  = cmp;
    frame_en   = en;
    frame_done = 1'b0;
    frame_req  = 1'b1;
    while (!frame_done)
      @(posedge clk_cpu);
  endtask

  task automatic spi_begin();
    @(negedge clk_cpu);
    spi_csn = 1'b0;
    wait_cycles(HALF);
  endtask

  // mode 0, msb first, miso taken just before the rising edge
  task automatic spi_byte(input spi_osd_pkg::osd_byte_t tx,
                          output spi_osd_pkg::osd_byte_t rx);
    for (int i = 7; i >= 0; i--)
    begin
      spi_mosi = tx[i];
      wait_cycles(HALF);
      rx[i] = spi_miso;
      spi_sclk = 1'b1;
      wait_cycles(HALF);
      spi_sclk = 1'b0;
    end
  endtask

  task automatic spi_end();
    wait_cycles(HALF);
    spi_csn  = 1'b1;
    spi_mosi = 1'b0;
    wait_cycles(2 * HALF);
  endtask

  // command byte, then region and a zero offset
  task automatic spi_command(input spi_osd_pkg::osd_byte_t cmd,
                             input spi_osd_pkg::osd_byte_t region);
    spi_osd_pkg::osd_byte_t rx;
    spi_byte(cmd, rx);
    spi_byte(region, rx);
    spi_byte(8'h00, rx);
    spi_byte(8'h00, rx);
    spi_byte(8'h00, rx);
  endtask

  task automatic spi_write_block(input spi_osd_pkg::osd_byte_t region, input int count);
    spi_osd_pkg::osd_byte_t rx;
    spi_begin();
    spi_command(8'h00, region);
    for (int i = 0; i < count; i++)
      spi_byte(tx_data[i], rx);
    spi_end();
  endtask

  task automatic spi_read_block(input spi_osd_pkg::osd_byte_t region, input int count);
    spi_begin();
    spi_command(8'h01, region);
    for (int i = 0; i < count; i++)
      spi_byte(8'h00, rx_data[i]);
    spi_end();
  endtask

  task automatic start_test();
    start_errors = errors;
    tests_run++;
  endtask

  task automatic finish_test(input string name);
    if (errors != start_errors)
      tests_failed++;
    $display("test %0d %s: %s", tests_run, name, (errors == start_errors) ? "pass" : "fail");
  endtask

  task automatic test_video_timing();
    start_test();
    while (!locked)
      @(posedge clk_cpu);
    run_frame(1'b0, 1'b0);
    compare_count(pix_count, `H_ACTIVE * `V_ACTIVE, "active pixels");
    compare_count(line_count, `V_ACTIVE, "active lines");
    compare_count(hs_count, `V_TOTAL, "hsync pulses");
    compare_count(vs_count, 1, "vsync pulses");
    finish_test("video timing");
  endtask

  task automatic test_plain_picture();
    start_test();
    run_frame(1'b1, 1'b0);
    finish_test("plain test picture");
  endtask

  task automatic test_ram_block();
    logic [31:0] rnd;
    start_test();
    for (int i = 0; i < 128; i++)
    begin
      rnd = $random(seed);
      tx_data[i] = rnd[7:0];
      bitmap[i]  = rnd[7:0];
    end
    spi_write_block(8'h00, 128);
    spi_read_block(8'h00, 128);
    for (int i = 0; i < 128; i++)
      compare_byte(rx_data[i], bitmap[i], "bitmap byte", i);
    finish_test("bitmap write and read back");
  endtask

  task automatic test_overlay_on();
    start_test();
    tx_data[0] = 8'h01;
    spi_write_block(8'h01, 1);
    run_frame(1'b1, 1'b1);
    finish_test("overlay enabled");
  endtask

  task automatic test_overlay_off();
    start_test();
    spi_read_block(8'h01, 1);
    compare_byte(rx_data[0], 8'h01, "enable readback", 0);
    tx_data[0] = 8'h00;
    spi_write_block(8'h01, 1);
    spi_read_block(8'h01, 1);
    compare_byte(rx_data[0], 8'h00, "enable readback", 1);
    run_frame(1'b1, 1'b0);
    finish_test("overlay disabled again");
  endtask

  initial
  begin
    rst_n        = 1'b0;
    spi_csn      = 1'b1;
    spi_sclk     = 1'b0;
    spi_mosi     = 1'b0;
    seed         = 53319;
    cycles       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    locked       = 1'b0;
    prev_hs      = 1'b0;
    prev_vs      = 1'b0;
    prev_bl      = 1'b1;
    frame_req    = 1'b0;
    frame_on     = 1'b0;
    frame_done   = 1'b0;
    frame_cmp    = 1'b0;
    frame_en     = 1'b0;
    for (int i = 0; i < 128; i++)
      bitmap[i] = 8'h00;
    wait_cycles(10);
    rst_n = 1'b1;
    test_video_timing();
    test_plain_picture();
    test_ram_block();
    test_overlay_on();
    test_overlay_off();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

/* spi_osd.f */
+incdir+design
design/spi_osd_pkg.sv
design/spi_ram_slave.sv
design/mem_arbiter.sv
design/osd_ram.sv
design/video_timing.sv
design/osd_overlay.sv
design/osd_char_top.sv
test/spi_osd_tb.sv
